/* rtl/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Memory depths in 16-bit words.
`define IMEM_WORDS 256
`define DMEM_WORDS 256

// APB address bit that selects data memory.
`define APB_DMEM_BIT 15

// Bit positions inside flags_t.
`define FLAG_Z 2
`define FLAG_V 1
`define FLAG_N 0

`endif

/* rtl/cpu_pkg.sv */
package cpu_pkg;

	typedef enum logic [3:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		XOR = 4'd2,
		SLL = 4'd4,
		SRA = 4'd5,
		LW  = 4'd8,
		SW  = 4'd9,
		LLB = 4'd10,
		LHB = 4'd11,
		B   = 4'd12,
		HLT = 4'd15
	} opcode_e;

	typedef enum logic [2:0] {
		NE, EQ, GT, LT, GE, LE, OV, UNCOND
	} ccode_e;

	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flags_t;

	typedef struct packed {
		logic        valid;
		logic [15:0] pc_plus2;
		logic [15:0] instr;
	} if_id_t;

	typedef struct packed {
		logic        valid;
		opcode_e     op;
		logic [3:0]  rs;
		logic [3:0]  rt;
		logic [3:0]  rd;
		logic [15:0] rs_val;
		logic [15:0] rt_val;
		logic [15:0] imm;      // Sign-extended, or LLB/LHB merge.
		logic [8:0]  br_off;
		ccode_e      cc;
		logic [15:0] pc_plus2;
		logic        reg_write;
		logic        mem_read;
	} id_ex_t;

	typedef struct packed {
		logic        valid;
		opcode_e     op;
		logic [3:0]  rd;
		logic [15:0] result;
		logic [15:0] store_data;
		logic        mem_read;
		logic        mem_write;
		logic        reg_write;
		logic        halt;
	} ex_mem_t;

	typedef struct packed {
		logic        valid;
		logic [3:0]  rd;
		logic [15:0] wb_data;
		logic        reg_write;
		logic        halt;
	} mem_wb_t;

	// Bypass from a later stage back to execute.
	typedef struct packed {
		logic [3:0]  rd;
		logic [15:0] data;
		logic        reg_write;
	} fwd_t;

endpackage

/* rtl/apb_loader.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module apb_loader (
	input  logic        clk,
	input  logic        reset_i,
	input  logic        run_i,
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [15:0] paddr_i,
	input  logic [15:0] pwdata_i,
	output logic        pready_o,
	output logic        pslverr_o,
	output logic [15:0] prdata_o,
	output logic        imem_we_o,
	output logic        dmem_we_o,
	output logic        dmem_re_o,
	output logic [7:0]  load_addr_o,
	output logic [15:0] load_data_o,
	input  logic [15:0] dmem_rdata_i
);
	logic access;
	logic to_dmem;
	logic ok;
	logic rd_wait_q;

	assign access = psel_i & penable_i;
	assign to_dmem = paddr_i[`APB_DMEM_BIT];
	assign ok = access & ~run_i; // Core held.

	assign imem_we_o = ok & pwrite_i & ~to_dmem;
	assign dmem_we_o = ok & pwrite_i & to_dmem;
	assign dmem_re_o = ok & ~pwrite_i & to_dmem & ~rd_wait_q;
	assign load_addr_o = paddr_i[8:1]; // Byte to word index.
	assign load_data_o = pwdata_i;

	assign pslverr_o = access & run_i;
	assign pready_o = access & (run_i | pwrite_i | ~to_dmem | rd_wait_q);
	// Instruction memory reads back as zero.
	assign prdata_o = rd_wait_q ? dmem_rdata_i : 16'h0000;

	always_ff @(posedge clk) begin
		if (reset_i)
			rd_wait_q <= 1'b0;
		else
			rd_wait_q <= dmem_re_o; // Data memory read is registered.
	end

	assert property (@(posedge clk) disable iff (reset_i)
		access && !pready_o |=> pready_o);

endmodule

/* rtl/fetch_stage.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module fetch_stage (
	input  logic             clk,
	input  logic             reset_i,
	input  logic             run_i,
	input  logic             halted_i,
	input  logic             stall_i,
	input  logic             br_taken_i,
	input  logic [15:0]      br_target_i,
	input  logic             imem_we_i,
	input  logic [7:0]       load_addr_i,
	input  logic [15:0]      load_data_i,
	output cpu_pkg::if_id_t  if_id_o,
	output logic [15:0]      pc_o
);
	import cpu_pkg::*;

	localparam int IDX_W = $clog2(`IMEM_WORDS);

	logic [15:0] imem [`IMEM_WORDS];
	logic [15:0] pc_q;
	logic [15:0] instr;
	if_id_t      if_id_q;
	logic        advance;

	assign advance = run_i & ~halted_i;
	assign instr = imem[pc_q[IDX_W:1]]; // Asynchronous read.

	always_ff @(posedge clk) begin
		if (imem_we_i)
			imem[load_addr_i] <= load_data_i;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			pc_q <= 16'h0000;
			if_id_q.valid <= 1'b0;
		end else if (advance) begin
			if (br_taken_i) begin
				pc_q <= br_target_i;
				if_id_q.valid <= 1'b0; // Squash the wrong-path fetch.
			end else if (!stall_i) begin
				pc_q <= pc_q + 16'd2;
				if_id_q.valid <= 1'b1;
				if_id_q.pc_plus2 <= pc_q + 16'd2;
				if_id_q.instr <= instr;
			end
		end
	end

	assign if_id_o = if_id_q;
	assign pc_o = pc_q;

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
	input  logic             clk,
	input  logic             reset_i,
	input  logic             run_i,
	input  logic             halted_i,
	input  cpu_pkg::if_id_t  if_id_i,
	input  logic             br_taken_i,
	input  cpu_pkg::mem_wb_t wb_i,
	input  logic [3:0]       ex_load_rd_i,
	input  logic             ex_load_i,
	output logic             stall_o,
	output cpu_pkg::id_ex_t  id_ex_o
);
	import cpu_pkg::*;

	logic [15:0] rf [16];
	opcode_e     op;
	logic [3:0]  rs;
	logic [3:0]  rt;
	logic [3:0]  rd;
	logic        use_rs;
	logic        use_rt;
	logic        reg_write;
	logic        mem_read;
	logic        wb_we;
	logic        advance;
	logic [15:0] rs_val;
	logic [15:0] rt_val;
	logic [15:0] imm;
	id_ex_t      id_ex_q;

	assign advance = run_i & ~halted_i;
	assign wb_we = advance & wb_i.valid & wb_i.reg_write;
	assign op = opcode_e'(if_id_i.instr[15:12]);
	assign rd = if_id_i.instr[11:8];

	always_comb begin
		rs = if_id_i.instr[7:4];
		rt = if_id_i.instr[3:0];
		use_rs = 1'b0;
		use_rt = 1'b0;
		reg_write = 1'b0;
		mem_read = 1'b0;
		case (op)
			ADD, SUB, XOR: begin
				use_rs = 1'b1;
				use_rt = 1'b1;
				reg_write = 1'b1;
			end
			SLL, SRA: begin
				use_rs = 1'b1;
				reg_write = 1'b1;
			end
			LW: begin
				use_rs = 1'b1;
				reg_write = 1'b1;
				mem_read = 1'b1;
			end
			SW: begin
				rt = if_id_i.instr[11:8]; // Store data register.
				use_rs = 1'b1;
				use_rt = 1'b1;
			end
			LLB, LHB: begin
				rs = rd;
				use_rs = 1'b1;
				reg_write = 1'b1;
			end
			default: ;
		endcase
		reg_write = reg_write & (rd != 4'd0); // R0 is never written.
	end

	// Write-through so a value retiring this cycle is seen.
	assign rs_val = (rs == 4'd0) ? 16'h0000 :
		(wb_we && wb_i.rd == rs) ? wb_i.wb_data : rf[rs];
	assign rt_val = (rt == 4'd0) ? 16'h0000 :
		(wb_we && wb_i.rd == rt) ? wb_i.wb_data : rf[rt];

	always_comb begin
		case (op)
			LLB: imm = {rs_val[15:8], if_id_i.instr[7:0]};
			LHB: imm = {if_id_i.instr[7:0], rs_val[7:0]};
			default: imm = {{12{if_id_i.instr[3]}}, if_id_i.instr[3:0]};
		endcase
	end

	// Load in execute feeding this instruction.
	assign stall_o = if_id_i.valid & ex_load_i &
		((use_rs & (rs == ex_load_rd_i)) | (use_rt & (rt == ex_load_rd_i)));

	always_ff @(posedge clk) begin
		if (wb_we && wb_i.rd != 4'd0)
			rf[wb_i.rd] <= wb_i.wb_data;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			id_ex_q.valid <= 1'b0;
		end else if (advance) begin
			id_ex_q.valid <= if_id_i.valid & ~br_taken_i & ~stall_o; // Bubble or flush.
			id_ex_q.op <= op;
			id_ex_q.rs <= rs;
			id_ex_q.rt <= rt;
			id_ex_q.rd <= rd;
			id_ex_q.rs_val <= rs_val;
			id_ex_q.rt_val <= rt_val;
			id_ex_q.imm <= imm;
			id_ex_q.br_off <= if_id_i.instr[8:0];
			id_ex_q.cc <= ccode_e'(if_id_i.instr[11:9]);
			id_ex_q.pc_plus2 <= if_id_i.pc_plus2;
			id_ex_q.reg_write <= reg_write;
			id_ex_q.mem_read <= mem_read;
		end
	end

	assign id_ex_o = id_ex_q;

	assert property (@(posedge clk) disable iff (reset_i)
		wb_we |-> wb_i.rd != 4'd0);

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module execute_stage (
	input  logic             clk,
	input  logic             reset_i,
	input  logic             run_i,
	input  logic             halted_i,
	input  cpu_pkg::id_ex_t  id_ex_i,
	input  cpu_pkg::fwd_t    fwd_mem_i,
	input  cpu_pkg::fwd_t    fwd_wb_i,
	output cpu_pkg::ex_mem_t ex_mem_o,
	output logic             br_taken_o,
	output logic [15:0]      br_target_o,
	output cpu_pkg::fwd_t    fwd_ex_o,
	output logic [3:0]       ex_load_rd_o,
	output logic             ex_load_o
);
	import cpu_pkg::*;

	function automatic logic [15:0] bypass(input logic [3:0] r, input logic [15:0] v,
			input fwd_t m, input fwd_t w);
		if (r != 4'd0 && m.reg_write && m.rd == r)
			return m.data; // Newest result wins.
		if (r != 4'd0 && w.reg_write && w.rd == r)
			return w.data;
		return v;
	endfunction

	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] result;
	logic        ovf;
	logic        cond;
	logic        advance;
	flags_t      flag_q;
	flags_t      flag_d;
	ex_mem_t     ex_mem_q;

	assign advance = run_i & ~halted_i;
	assign a = bypass(id_ex_i.rs, id_ex_i.rs_val, fwd_mem_i, fwd_wb_i);
	assign b = bypass(id_ex_i.rt, id_ex_i.rt_val, fwd_mem_i, fwd_wb_i);

	always_comb begin
		ovf = 1'b0;
		case (id_ex_i.op)
			ADD: begin
				result = a + b;
				ovf = (a[15] == b[15]) && (result[15] != a[15]);
			end
			SUB: begin
				result = a - b;
				ovf = (a[15] != b[15]) && (result[15] != a[15]);
			end
			XOR: result = a ^ b;
			SLL: result = a << id_ex_i.imm[3:0];
			SRA: result = $signed(a) >>> id_ex_i.imm[3:0];
			LW, SW: result = a + {id_ex_i.imm[14:0], 1'b0}; // Word offset.
			LLB: result = {a[15:8], id_ex_i.imm[7:0]};
			LHB: result = {id_ex_i.imm[15:8], a[7:0]};
			default: result = 16'h0000;
		endcase
		flag_d[`FLAG_Z] = (result == 16'h0000);
		flag_d[`FLAG_V] = ovf;
		flag_d[`FLAG_N] = result[15];
	end

	always_comb begin
		case (id_ex_i.cc)
			NE: cond = !flag_q[`FLAG_Z];
			EQ: cond = flag_q[`FLAG_Z];
			GT: cond = !flag_q[`FLAG_Z] && !flag_q[`FLAG_N];
			LT: cond = flag_q[`FLAG_N];
			GE: cond = flag_q[`FLAG_Z] || !flag_q[`FLAG_N];
			LE: cond = flag_q[`FLAG_Z] || flag_q[`FLAG_N];
			OV: cond = flag_q[`FLAG_V];
			default: cond = 1'b1;
		endcase
	end

	assign br_taken_o = advance & id_ex_i.valid & (id_ex_i.op == B) & cond;
	assign br_target_o = id_ex_i.pc_plus2 +
		{{6{id_ex_i.br_off[8]}}, id_ex_i.br_off, 1'b0};

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ex_mem_q.valid <= 1'b0;
			flag_q <= '0;
		end else if (advance) begin
			ex_mem_q.valid <= id_ex_i.valid;
			ex_mem_q.op <= id_ex_i.op;
			ex_mem_q.rd <= id_ex_i.rd;
			ex_mem_q.result <= result;
			ex_mem_q.store_data <= b;
			ex_mem_q.mem_read <= id_ex_i.mem_read;
			ex_mem_q.mem_write <= (id_ex_i.op == SW);
			ex_mem_q.reg_write <= id_ex_i.reg_write;
			ex_mem_q.halt <= (id_ex_i.op == HLT);
			if (id_ex_i.valid && (id_ex_i.op == ADD || id_ex_i.op == SUB || id_ex_i.op == XOR))
				flag_q <= flag_d;
		end
	end

	assign ex_mem_o = ex_mem_q;
	// Load results are not ready in EX/MEM.
	assign fwd_ex_o.rd = ex_mem_q.rd;
	assign fwd_ex_o.data = ex_mem_q.result;
	assign fwd_ex_o.reg_write = ex_mem_q.valid & ex_mem_q.reg_write & ~ex_mem_q.mem_read;
	assign ex_load_rd_o = id_ex_i.rd;
	assign ex_load_o = id_ex_i.valid & id_ex_i.mem_read & id_ex_i.reg_write;

	// Taken branch squashes the next ID/EX entry.
	assert property (@(posedge clk) disable iff (reset_i)
		br_taken_o |=> !id_ex_i.valid);

endmodule

/* rtl/memory_stage.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module memory_stage (
	input  logic             clk,
	input  logic             reset_i,
	input  logic             run_i,
	input  logic             halted_i,
	input  cpu_pkg::ex_mem_t ex_mem_i,
	input  logic             dmem_we_i,
	input  logic             dmem_re_i,
	input  logic [7:0]       load_addr_i,
	input  logic [15:0]      load_data_i,
	output cpu_pkg::mem_wb_t mem_wb_o,
	output cpu_pkg::fwd_t    fwd_mem_o,
	output cpu_pkg::fwd_t    fwd_wb_o,
	output logic [15:0]      dmem_rdata_o,
	output logic             halted_o
);
	import cpu_pkg::*;

	localparam int IDX_W = $clog2(`DMEM_WORDS);

	logic [15:0]      dmem [`DMEM_WORDS];
	logic [IDX_W-1:0] idx;
	logic [15:0]      ld_data_q;
	logic [15:0]      dbg_data_q;
	logic             ld_sel_q;
	logic             halted_q;
	logic             advance;
	mem_wb_t          mem_wb_q;

	assign advance = run_i & ~halted_i;
	assign idx = ex_mem_i.result[IDX_W:1];

	always_ff @(posedge clk) begin
		if (advance && ex_mem_i.valid && ex_mem_i.mem_write)
			dmem[idx] <= ex_mem_i.store_data;
		else if (!run_i && dmem_we_i)
			dmem[load_addr_i] <= load_data_i; // Debug port.
		if (advance && ex_mem_i.mem_read)
			ld_data_q <= dmem[idx];
		if (!run_i && dmem_re_i)
			dbg_data_q <= dmem[load_addr_i];
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			mem_wb_q.valid <= 1'b0;
			ld_sel_q <= 1'b0;
			halted_q <= 1'b0;
		end else if (advance) begin
			mem_wb_q.valid <= ex_mem_i.valid;
			mem_wb_q.rd <= ex_mem_i.rd;
			mem_wb_q.wb_data <= ex_mem_i.result;
			mem_wb_q.reg_write <= ex_mem_i.reg_write;
			mem_wb_q.halt <= ex_mem_i.halt;
			ld_sel_q <= ex_mem_i.mem_read;
			if (ex_mem_i.valid && ex_mem_i.halt)
				halted_q <= 1'b1; // Sticky until reset.
		end
	end

	always_comb begin
		mem_wb_o = mem_wb_q;
		if (ld_sel_q)
			mem_wb_o.wb_data = ld_data_q;
	end

	assign fwd_mem_o.rd = ex_mem_i.rd;
	assign fwd_mem_o.data = ex_mem_i.result;
	assign fwd_mem_o.reg_write = ex_mem_i.valid & ex_mem_i.reg_write & ~ex_mem_i.mem_read;
	assign fwd_wb_o.rd = mem_wb_o.rd;
	assign fwd_wb_o.data = mem_wb_o.wb_data;
	assign fwd_wb_o.reg_write = mem_wb_o.valid & mem_wb_o.reg_write;
	assign dmem_rdata_o = dbg_data_q;
	assign halted_o = halted_q;

endmodule

/* rtl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
	input  logic        clk,
	input  logic        reset_i,
	input  logic        run_i,
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [15:0] paddr_i,
	input  logic [15:0] pwdata_i,
	output logic        pready_o,
	output logic        pslverr_o,
	output logic [15:0] prdata_o,
	output logic        hlt_o,
	output logic [15:0] pc_o
);
	import cpu_pkg::*;

	logic        imem_we;
	logic        dmem_we;
	logic        dmem_re;
	logic [7:0]  load_addr;
	logic [15:0] load_data;
	logic [15:0] dmem_rdata;
	logic        halted;
	logic        stall;
	logic        br_taken;
	logic [15:0] br_target;
	logic [3:0]  ex_load_rd;
	logic        ex_load;
	if_id_t      if_id;
	id_ex_t      id_ex;
	ex_mem_t     ex_mem;
	mem_wb_t     mem_wb;
	fwd_t        fwd_ex;
	fwd_t        fwd_wb;

	apb_loader u_apb_loader (.clk(clk), .reset_i(reset_i), .run_i(run_i),
		.psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
		.paddr_i(paddr_i), .pwdata_i(pwdata_i), .pready_o(pready_o),
		.pslverr_o(pslverr_o), .prdata_o(prdata_o), .imem_we_o(imem_we),
		.dmem_we_o(dmem_we), .dmem_re_o(dmem_re), .load_addr_o(load_addr),
		.load_data_o(load_data), .dmem_rdata_i(dmem_rdata));

	fetch_stage u_fetch (.clk(clk), .reset_i(reset_i), .run_i(run_i),
		.halted_i(halted), .stall_i(stall), .br_taken_i(br_taken),
		.br_target_i(br_target), .imem_we_i(imem_we), .load_addr_i(load_addr),
		.load_data_i(load_data), .if_id_o(if_id), .pc_o(pc_o));

	decode_stage u_decode (.clk(clk), .reset_i(reset_i), .run_i(run_i),
		.halted_i(halted), .if_id_i(if_id), .br_taken_i(br_taken), .wb_i(mem_wb),
		.ex_load_rd_i(ex_load_rd), .ex_load_i(ex_load), .stall_o(stall),
		.id_ex_o(id_ex));

	// EX/MEM bypass comes from execute's own register.
	execute_stage u_execute (.clk(clk), .reset_i(reset_i), .run_i(run_i),
		.halted_i(halted), .id_ex_i(id_ex), .fwd_mem_i(fwd_ex), .fwd_wb_i(fwd_wb),
		.ex_mem_o(ex_mem), .br_taken_o(br_taken), .br_target_o(br_target),
		.fwd_ex_o(fwd_ex), .ex_load_rd_o(ex_load_rd), .ex_load_o(ex_load));

	memory_stage u_memory (.clk(clk), .reset_i(reset_i), .run_i(run_i),
		.halted_i(halted), .ex_mem_i(ex_mem), .dmem_we_i(dmem_we),
		.dmem_re_i(dmem_re), .load_addr_i(load_addr), .load_data_i(load_data),
		.mem_wb_o(mem_wb), .fwd_mem_o(), .fwd_wb_o(fwd_wb),
		.dmem_rdata_o(dmem_rdata), .halted_o(halted));

	assign hlt_o = halted;

endmodule

/* tb/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_tb;
	import cpu_pkg::*;

	localparam int CHECK_WORDS = 96; // Data words preloaded and compared.

	logic        clk;
	logic        reset_i;
	logic        run_i;
	logic        psel_i;
	logic        penable_i;
	logic        pwrite_i;
	logic [15:0] paddr_i;
	logic [15:0] pwdata_i;
	logic        pready_o;
	logic        pslverr_o;
	logic [15:0] prdata_o;
	logic        hlt_o;
	logic [15:0] pc_o;

	integer      seed = 32'h93e2_69dc;
	int          cycles = 0;
	int          budget = 100;
	logic [15:0] prog [$];
	logic [15:0] m_rf [16];
	logic [15:0] m_dmem [256];
	logic        m_z;
	logic        m_v;
	logic        m_n;

	cpu_top u_cpu_top (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > budget) begin
			$display("Timeout: the run took more than %0d cycles", budget);
			$display("Something failed");
			$fatal(1, "timeout");
		end
	end

	task automatic stop_with_failure();
		$display("Something failed");
		$fatal(1, "check failed");
	endtask

	task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_flag_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_pslverr(input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] pslverr_o got %h expected %h", got, exp);
			stop_with_failure();
		end
	endtask

	function automatic logic [15:0] dmem_addr(input int idx);
		logic [15:0] addr;
		addr = 16'(idx * 2);
		addr[`APB_DMEM_BIT] = 1'b1;
		return addr;
	endfunction

	// Setup and access phase, sampled mid-cycle.
	task automatic apb_access(input logic write, input logic [15:0] addr,
			input logic [15:0] wdata, output logic [15:0] rdata, output logic err);
		logic ready;
		budget += 200;
		@(negedge clk);
		psel_i = 1'b1;
		penable_i = 1'b0;
		pwrite_i = write;
		paddr_i = addr;
		pwdata_i = wdata;
		@(negedge clk);
		penable_i = 1'b1;
		ready = 1'b0;
		while (!ready) begin
			#1;
			ready = pready_o;
			rdata = prdata_o;
			err = pslverr_o;
			@(negedge clk);
		end
		psel_i = 1'b0;
		penable_i = 1'b0;
	endtask

	task automatic apb_write(input logic [15:0] addr, input logic [15:0] data, input logic exp_err);
		logic [15:0] unused;
		logic        err;
		apb_access(1'b1, addr, data, unused, err);
		check_pslverr(err, exp_err);
		if (!exp_err && addr[`APB_DMEM_BIT])
			m_dmem[addr[8:1]] = data;
	endtask

	task automatic apb_read(input logic [15:0] addr, output logic [15:0] data, input logic exp_err);
		logic err;
		apb_access(1'b0, addr, 16'h0000, data, err);
		check_pslverr(err, exp_err);
	endtask

	function automatic logic [15:0] rrr(input opcode_e op, input logic [3:0] rd,
			input logic [3:0] rs, input logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic logic [15:0] byte_word(input opcode_e op, input logic [3:0] rd,
			input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic logic [15:0] branch_word(input ccode_e cc, input logic [8:0] off);
		return {B, cc, off};
	endfunction

	task automatic load_const(input logic [3:0] rd, input logic [15:0] value);
		prog.push_back(byte_word(LLB, rd, value[7:0]));
		prog.push_back(byte_word(LHB, rd, value[15:8]));
	endtask

	function automatic logic [15:0] reg_value(input logic [3:0] r);
		return (r == 4'd0) ? 16'h0000 : m_rf[r];
	endfunction

	// Sequential ISA model, run to the first HLT.
	task automatic run_model();
		int          pc;
		int          steps;
		logic [15:0] ins;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] r;
		logic [15:0] addr;
		logic        take;
		pc = 0;
		m_z = 1'b0;
		m_v = 1'b0;
		m_n = 1'b0;
		for (steps = 0; steps < 1000; steps++) begin
			if (pc >= prog.size()) begin
				$display("Model ran past the end of the program");
				stop_with_failure();
			end
			ins = prog[pc];
			pc++;
			a = reg_value(ins[7:4]);
			b = reg_value(ins[3:0]);
			addr = a + {{11{ins[3]}}, ins[3:0], 1'b0};
			r = 16'h0000;
			case (opcode_e'(ins[15:12]))
				ADD, SUB, XOR: begin
					if (ins[15:12] == ADD) begin
						r = a + b;
						m_v = (a[15] == b[15]) && (r[15] != a[15]);
					end else if (ins[15:12] == SUB) begin
						r = a - b;
						m_v = (a[15] != b[15]) && (r[15] != a[15]);
					end else begin
						r = a ^ b;
						m_v = 1'b0;
					end
					m_z = (r == 16'h0000);
					m_n = r[15];
				end
				SLL: r = a << ins[3:0];
				SRA: r = $signed(a) >>> ins[3:0];
				LW: r = m_dmem[addr[8:1]];
				SW: m_dmem[addr[8:1]] = reg_value(ins[11:8]);
				LLB: r = (reg_value(ins[11:8]) & 16'hff00) | {8'h00, ins[7:0]};
				LHB: r = {ins[7:0], 8'h00} | (reg_value(ins[11:8]) & 16'h00ff);
				B: begin
					case (ccode_e'(ins[11:9]))
						NE: take = !m_z;
						EQ: take = m_z;
						GT: take = !m_z && !m_n;
						LT: take = m_n;
						GE: take = m_z || !m_n;
						LE: take = m_z || m_n;
						OV: take = m_v;
						default: take = 1'b1;
					endcase
					if (take)
						pc = pc + int'($signed(ins[8:0]));
				end
				HLT: return;
				default: ;
			endcase
			if (ins[15:12] inside {ADD, SUB, XOR, SLL, SRA, LW, LLB, LHB} && ins[11:8] != 4'd0)
				m_rf[ins[11:8]] = r;
		end
		$display("Model did not reach HLT");
		stop_with_failure();
	endtask

	task automatic do_reset();
		@(negedge clk);
		reset_i = 1'b1;
		repeat (5) @(negedge clk);
		reset_i = 1'b0;
	endtask

	task automatic start_program();
		budget += 40 * prog.size();
		do_reset();
		for (int i = 0; i < prog.size(); i++)
			apb_write(16'(i * 2), prog[i], 1'b0);
		run_model();
		@(negedge clk);
		run_i = 1'b1;
		while (!hlt_o)
			@(negedge clk);
	endtask

	task automatic compare_memory();
		logic [15:0] d;
		for (int i = 0; i < CHECK_WORDS; i++) begin
			apb_read(dmem_addr(i), d, 1'b0);
			check_word($sformatf("dmem[%0d]", i), d, m_dmem[i]);
		end
	endtask

	task automatic finish_program();
		@(negedge clk);
		run_i = 1'b0;
		compare_memory();
	endtask

	task automatic test_apb_loading();
		logic [15:0] d;
		for (int i = 0; i < CHECK_WORDS; i++)
			apb_write(dmem_addr(i), 16'($random(seed)), 1'b0);
		compare_memory();
		apb_write(16'h0004, 16'ha5a5, 1'b0);
		apb_read(16'h0004, d, 1'b0);
		check_word("prdata_o", d, 16'h0000); // Instruction memory reads as zero.
	endtask

	task automatic test_arithmetic();
		prog.delete();
		load_const(4'd1, 16'($random(seed)));
		load_const(4'd2, 16'($random(seed)));
		load_const(4'd9, 16'h0020);
		prog.push_back(rrr(ADD, 4'd3, 4'd1, 4'd2));
		prog.push_back(rrr(SUB, 4'd4, 4'd3, 4'd1));
		prog.push_back(rrr(XOR, 4'd5, 4'd4, 4'd3));
		prog.push_back(rrr(SLL, 4'd6, 4'd5, 4'd3));
		prog.push_back(rrr(SRA, 4'd7, 4'd6, 4'd5));
		prog.push_back(rrr(ADD, 4'd8, 4'd7, 4'd7));
		prog.push_back(rrr(SW, 4'd8, 4'd9, 4'd5));
		prog.push_back(rrr(SW, 4'd3, 4'd9, 4'd0));
		prog.push_back(rrr(SW, 4'd4, 4'd9, 4'd1));
		prog.push_back(rrr(SW, 4'd5, 4'd9, 4'd2));
		prog.push_back(rrr(SW, 4'd6, 4'd9, 4'd3));
		prog.push_back(rrr(SW, 4'd7, 4'd9, 4'd4));
		prog.push_back({HLT, 12'h000});
		start_program();
		finish_program();
	endtask

	task automatic test_load_use();
		prog.delete();
		load_const(4'd1, 16'h0040);
		prog.push_back(rrr(LW, 4'd2, 4'd1, 4'd0));
		prog.push_back(rrr(ADD, 4'd3, 4'd2, 4'd2)); // Consumer right after the load.
		prog.push_back(rrr(LW, 4'd4, 4'd1, 4'd1));
		prog.push_back(rrr(SW, 4'd4, 4'd1, 4'd4));
		prog.push_back(rrr(SW, 4'd3, 4'd1, 4'd5));
		prog.push_back(rrr(LW, 4'd5, 4'd1, 4'd2));
		prog.push_back(rrr(SUB, 4'd6, 4'd5, 4'd3));
		prog.push_back(rrr(XOR, 4'd7, 4'd6, 4'd5));
		prog.push_back(rrr(SW, 4'd7, 4'd1, 4'd6));
		prog.push_back(rrr(SW, 4'd6, 4'd1, 4'd7));
		prog.push_back({HLT, 12'h000});
		start_program();
		finish_program();
	endtask

	task automatic test_branches();
		ccode_e cc_list [15] = '{NE, NE, EQ, EQ, GT, GT, LT, LT, GE, GE, LE, LE, OV, OV, UNCOND};
		int     kind_list [15] = '{2, 0, 0, 2, 2, 0, 1, 2, 0, 1, 1, 2, 3, 2, 0};
		prog.delete();
		load_const(4'd1, 16'd5);
		load_const(4'd2, 16'd5);
		load_const(4'd3, 16'd3);
		load_const(4'd4, 16'h7fff);
		load_const(4'd6, 16'd1);
		load_const(4'd9, 16'h007c);
		load_const(4'd10, 16'hdead);
		load_const(4'd11, 16'hbeef);
		load_const(4'd12, 16'd4);
		for (int k = 0; k < 15; k++) begin
			prog.push_back(rrr(ADD, 4'd9, 4'd9, 4'd12));
			case (kind_list[k])
				0: prog.push_back(rrr(SUB, 4'd7, 4'd1, 4'd2)); // Zero.
				1: prog.push_back(rrr(SUB, 4'd7, 4'd3, 4'd1)); // Negative.
				2: prog.push_back(rrr(SUB, 4'd7, 4'd1, 4'd3));
				default: prog.push_back(rrr(ADD, 4'd7, 4'd4, 4'd6)); // Overflow.
			endcase
			prog.push_back(branch_word(cc_list[k], 9'd2));
			prog.push_back(rrr(SW, 4'd10, 4'd9, 4'd0));
			prog.push_back(rrr(SW, 4'd11, 4'd9, 4'd1));
		end
		prog.push_back({HLT, 12'h000});
		start_program();
		finish_program();
	endtask

	task automatic test_halt_and_r0();
		logic [15:0] pc_held;
		logic [15:0] d;
		prog.delete();
		load_const(4'd1, 16'h1234);
		load_const(4'd2, 16'h0010);
		prog.push_back(rrr(ADD, 4'd0, 4'd1, 4'd1));
		prog.push_back(byte_word(LLB, 4'd0, 8'h55));
		prog.push_back(rrr(SW, 4'd0, 4'd2, 4'd0));
		prog.push_back(rrr(ADD, 4'd3, 4'd0, 4'd1));
		prog.push_back(rrr(SW, 4'd3, 4'd2, 4'd1));
		prog.push_back({HLT, 12'h000});
		prog.push_back(rrr(SW, 4'd1, 4'd2, 4'd2)); // Past HLT, never retires.
		start_program();
		pc_held = pc_o;
		repeat (20) begin
			@(negedge clk);
			check_word("pc_o", pc_o, pc_held);
			check_flag_bit("hlt_o", hlt_o, 1'b1);
		end
		apb_write(dmem_addr(3), ~m_dmem[3], 1'b1);
		apb_read(dmem_addr(3), d, 1'b1);
		finish_program();
		apb_read(dmem_addr(8), d, 1'b0);
		check_word("dmem[8]", d, 16'h0000); // R0 stored as zero.
	endtask

	initial begin
		reset_i = 1'b1;
		run_i = 1'b0;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		paddr_i = 16'h0000;
		pwdata_i = 16'h0000;
		for (int i = 0; i < 16; i++)
			m_rf[i] = 16'h0000;
		do_reset();
		check_flag_bit("hlt_o", hlt_o, 1'b0);
		check_word("pc_o", pc_o, 16'h0000);
		test_apb_loading();
		test_arithmetic();
		test_load_use();
		test_branches();
		test_halt_and_r0();
		$display("Everything OK");
		$finish;
	end

endmodule

/* compile.f */
+incdir+rtl
rtl/cpu_pkg.sv
rtl/apb_loader.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu_top.sv
tb/cpu_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f compile.f --top-module cpu_tb -o cpu_tb_sim
./obj_dir/cpu_tb_sim
